//--- common/lsu_pkg.sv
// Types for the LSU data request path, which assumes a 32-bit address and a 32-bit data bus
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////
  // Request and response words
  ////////////////////////////////////////

  // One load or store as issued by the core
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } obi_data_req_t;

  // Reply from the memory bus
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_resp_t;

  // Protection result, a fault is reported by direction
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef enum logic {
    ALIGN_OK  = 1'b0,
    ALIGN_ERR = 1'b1
  } align_status_e;

  // Full response word returned to the core
  typedef struct packed {
    bus_resp_t     bus_resp;
    mpu_status_e   mpu_status;
    align_status_e align_status;
    logic          wpt_match;
  } data_resp_t;

  ////////////////////////////////////////
  // Debug trigger settings
  ////////////////////////////////////////

  // The address is compared on its word bits only
  typedef struct packed {
    logic [31:0] addr;
    logic        match_load;
    logic        match_store;
  } trigger_cfg_t;

  ////////////////////////////////////////
  // State machine encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    WPT_IDLE       = 2'b00,
    WPT_MATCH_WAIT = 2'b01,
    WPT_MATCH_RESP = 2'b10
  } wpt_state_e;

  typedef enum logic [1:0] {
    MPU_IDLE          = 2'b00,
    MPU_RE_FAULT_WAIT = 2'b01,
    MPU_WR_FAULT_WAIT = 2'b10,
    MPU_RESP          = 2'b11
  } mpu_state_e;

endpackage

`default_nettype wire

//--- verilog/lsu_trigger_match.sv
// Purely combinational watchpoint compare; byte offset bits [1:0] never take part in a match
`timescale 1ns/1ns
`default_nettype none

module lsu_trigger_match import lsu_pkg::*; #(
  parameter int NUM_TRIGGERS = 2
) (
  // Request as seen on the limiter side of the path
  input  obi_data_req_t                    trans_i,

  // Watchpoint settings, held stable by the top level
  input  trigger_cfg_t [NUM_TRIGGERS-1:0]  trig_cfg_i,

  // High when at least one watchpoint fires for trans_i
  output logic                             trigger_match_o
);

  // Per-trigger address compare result
  logic [NUM_TRIGGERS-1:0] addr_hit;

  // Per-trigger direction enable for the current request
  logic [NUM_TRIGGERS-1:0] dir_hit;

  // Triggers that fire in this cycle
  logic [NUM_TRIGGERS-1:0] trig_fire;

  ////////////////////////////////////////
  // Per-trigger compare
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      // Only the word part of the address is compared
      addr_hit[i] = (trig_cfg_i[i].addr[31:2] == trans_i.addr[31:2]);

      // Stores look at match_store and loads at match_load
      if (trans_i.we) begin
        dir_hit[i] = trig_cfg_i[i].match_store;
      end else begin
        dir_hit[i] = trig_cfg_i[i].match_load;
      end
    end
  end

  // A trigger fires only when both the address and the direction agree
  assign trig_fire = addr_hit & dir_hit;

  ////////////////////////////////////////
  // Combined result
  ////////////////////////////////////////

  // Any single trigger is enough to claim the transaction
  assign trigger_match_o = |trig_fire;

endmodule

`default_nettype wire

//--- verilog/lsu_txn_limiter.sv
// Outstanding transaction counter; core_resp_valid_i must pulse exactly once per accepted request
`timescale 1ns/1ns
`default_nettype none

module lsu_txn_limiter #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic clk,
  input  logic rst_n,

  // Core request handshake
  input  logic core_trans_valid_i,
  output logic core_trans_ready_o,

  // Response pulse seen by the core
  input  logic core_resp_valid_i,

  // Handshake towards the watchpoint stage
  output logic lim_trans_valid_o,
  input  logic lim_trans_ready_i,

  // Exactly one transaction will be outstanding next cycle
  output logic one_txn_pend_n_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_n;
  logic             full;
  logic             accept;

  // Full only looks at the registered count
  assign full = (count_q == CNT_W'(MAX_OUTSTANDING));

  // Hold the request back while full
  assign lim_trans_valid_o  = core_trans_valid_i && !full;
  assign core_trans_ready_o = lim_trans_ready_i && !full;
  assign accept             = core_trans_valid_i && core_trans_ready_o;

  // Next count after this cycle's accept and response
  always_comb begin
    case ({accept, core_resp_valid_i})
      2'b10:   count_n = count_q + CNT_W'(1);
      2'b01:   count_n = count_q - CNT_W'(1);
      default: count_n = count_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_n;
    end
  end

  assign one_txn_pend_n_o = (count_n == CNT_W'(1));

endmodule

`default_nettype wire

//--- wpt/lsu_wpt.sv
// Watchpoint stage; the core always accepts a response and the pending count covers all stages
`timescale 1ns/1ns
`default_nettype none

module lsu_wpt import lsu_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,

  // From the trigger compare block, same cycle as the request
  input  logic          trigger_match_i,

  // Request side towards the core
  input  logic          core_trans_valid_i,
  output logic          core_trans_ready_o,
  input  obi_data_req_t core_trans_i,

  // Request side towards the protection stage
  output logic          mpu_trans_valid_o,
  input  logic          mpu_trans_ready_i,
  output obi_data_req_t mpu_trans_o,

  // Response from the protection stage
  input  logic          mpu_resp_valid_i,
  input  data_resp_t    mpu_resp_i,

  // Response towards the core
  output logic          core_resp_valid_o,
  output data_resp_t    core_resp_o,

  // High when exactly one transaction will be outstanding next cycle
  input  logic          core_one_txn_pend_n_i
);

  wpt_state_e state_q;
  wpt_state_e state_n;

  logic wpt_block_core;
  logic wpt_block_bus;
  logic wpt_trans_ready;
  logic wpt_trans_valid;
  logic wpt_match;

  ////////////////////////////////////////
  // Watchpoint FSM
  ////////////////////////////////////////

  // A hit is claimed here and never forwarded downstream
  // The answer waits until the claimed transaction is the only one left
  // Nothing new is accepted between the claim and the answer
  always_comb begin
    state_n         = state_q;
    wpt_block_core  = 1'b0;
    wpt_block_bus   = 1'b0;
    wpt_trans_ready = 1'b0;
    wpt_trans_valid = 1'b0;
    wpt_match       = 1'b0;

    case (state_q)
      WPT_IDLE: begin
        if (trigger_match_i && core_trans_valid_i) begin
          // Keep the hit away from the protection stage
          wpt_block_bus = 1'b1;
          // Claim it only when the protection stage is not busy with a fault of its own
          if (mpu_trans_ready_i) begin
            wpt_trans_ready = 1'b1;
            state_n = core_one_txn_pend_n_i ? WPT_MATCH_RESP : WPT_MATCH_WAIT;
          end
        end
      end
      WPT_MATCH_WAIT: begin
        // Older transactions are still draining
        wpt_block_core = 1'b1;
        wpt_block_bus  = 1'b1;
        if (core_one_txn_pend_n_i) begin
          state_n = WPT_MATCH_RESP;
        end
      end
      WPT_MATCH_RESP: begin
        wpt_block_core  = 1'b1;
        wpt_block_bus   = 1'b1;
        wpt_trans_valid = 1'b1;
        wpt_match       = 1'b1;
        // The response is a single pulse so we always return to idle
        state_n = WPT_IDLE;
      end
      default: begin
        state_n = WPT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WPT_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////

  // Valid is built without looking at any ready
  assign mpu_trans_valid_o = core_trans_valid_i && !wpt_block_bus;
  assign mpu_trans_o       = core_trans_i;

  // Either the downstream path takes it or this stage claims it
  assign core_trans_ready_o = (mpu_trans_ready_i && !wpt_block_core) || wpt_trans_ready;

  assign core_resp_valid_o = mpu_resp_valid_i || wpt_trans_valid;

  // All fields pass through, wpt_match comes only from this stage
  always_comb begin
    core_resp_o           = mpu_resp_i;
    core_resp_o.wpt_match = wpt_match;
  end

endmodule

`default_nettype wire

//--- mpu/lsu_mpu.sv
// Protection stage; a misaligned address wins over a denied one and faults never reach the bus
`timescale 1ns/1ns
`default_nettype none

module lsu_mpu import lsu_pkg::*; #(
  parameter logic [31:0] DENY_BASE = 32'h0000_8000,
  parameter logic [31:0] DENY_MASK = 32'hFFFF_C000
) (
  input  logic          clk,
  input  logic          rst_n,

  // Request side from the watchpoint stage
  input  logic          core_trans_valid_i,
  output logic          core_trans_ready_o,
  input  obi_data_req_t core_trans_i,

  // High when exactly one transaction will be outstanding next cycle
  input  logic          core_one_txn_pend_n_i,

  // Memory bus request
  output logic          bus_req_valid_o,
  input  logic          bus_req_ready_i,
  output obi_data_req_t bus_req_o,

  // Memory bus response
  input  logic          bus_resp_valid_i,
  input  bus_resp_t     bus_resp_i,

  // Response towards the watchpoint stage
  output logic          core_resp_valid_o,
  output data_resp_t    core_resp_o
);

  mpu_state_e state_q;
  mpu_state_e state_n;

  logic          misaligned;
  logic          denied;
  logic          fault;
  mpu_status_e   fault_mpu_n;
  align_status_e fault_align_n;
  mpu_status_e   fault_mpu_q;
  align_status_e fault_align_q;
  logic          fault_load;

  logic mpu_block_core;
  logic mpu_block_bus;
  logic mpu_trans_ready;
  logic mpu_resp_valid;

  ////////////////////////////////////////
  // Address checks
  ////////////////////////////////////////

  assign misaligned = (core_trans_i.addr[1:0] != 2'b00);
  assign denied     = ((core_trans_i.addr & DENY_MASK) == DENY_BASE);
  assign fault      = misaligned || denied;

  // Status that a fault in this cycle would report
  always_comb begin
    fault_mpu_n   = MPU_OK;
    fault_align_n = ALIGN_OK;
    if (misaligned) begin
      fault_align_n = ALIGN_ERR;
    end else if (denied) begin
      fault_mpu_n = core_trans_i.we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end
  end

  ////////////////////////////////////////
  // Fault FSM
  ////////////////////////////////////////

  // Same claim, wait and answer scheme as the watchpoint stage
  always_comb begin
    state_n         = state_q;
    mpu_block_core  = 1'b0;
    mpu_block_bus   = 1'b0;
    mpu_trans_ready = 1'b0;
    mpu_resp_valid  = 1'b0;
    fault_load      = 1'b0;

    case (state_q)
      MPU_IDLE: begin
        if (core_trans_valid_i && fault) begin
          mpu_block_bus   = 1'b1;
          mpu_trans_ready = 1'b1;
          fault_load      = 1'b1;
          if (core_one_txn_pend_n_i) begin
            state_n = MPU_RESP;
          end else begin
            state_n = core_trans_i.we ? MPU_WR_FAULT_WAIT : MPU_RE_FAULT_WAIT;
          end
        end
      end
      MPU_RE_FAULT_WAIT, MPU_WR_FAULT_WAIT: begin
        mpu_block_core = 1'b1;
        mpu_block_bus  = 1'b1;
        if (core_one_txn_pend_n_i) begin
          state_n = MPU_RESP;
        end
      end
      MPU_RESP: begin
        mpu_block_core = 1'b1;
        mpu_block_bus  = 1'b1;
        mpu_resp_valid = 1'b1;
        state_n        = MPU_IDLE;
      end
      default: begin
        state_n = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // Status of the claimed fault, held for the answer in MPU_RESP
  always_ff @(posedge clk) begin
    if (fault_load) begin
      fault_mpu_q   <= fault_mpu_n;
      fault_align_q <= fault_align_n;
    end
  end

  ////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////

  assign bus_req_valid_o = core_trans_valid_i && !mpu_block_bus;
  assign bus_req_o       = core_trans_i;

  // Ready stays high in idle with no request so that an upstream claim can go ahead
  assign core_trans_ready_o = (!mpu_block_core && (bus_req_ready_i || !core_trans_valid_i))
                              || mpu_trans_ready;

  assign core_resp_valid_o = bus_resp_valid_i || mpu_resp_valid;

  // Idle response path carries zero data and OK status
  always_comb begin
    core_resp_o              = '0;
    core_resp_o.mpu_status   = MPU_OK;
    core_resp_o.align_status = ALIGN_OK;
    if (bus_resp_valid_i) begin
      core_resp_o.bus_resp = bus_resp_i;
    end
    if (mpu_resp_valid) begin
      core_resp_o.mpu_status   = fault_mpu_q;
      core_resp_o.align_status = fault_align_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_data_top.sv
// LSU data request path top; trig_cfg_i is expected to change only while no request is in flight
`timescale 1ns/1ns
`default_nettype none

module lsu_data_top import lsu_pkg::*; #(
  parameter int          NUM_TRIGGERS    = 2,
  parameter int          MAX_OUTSTANDING = 2,
  parameter logic [31:0] DENY_BASE       = 32'h0000_8000,
  parameter logic [31:0] DENY_MASK       = 32'hFFFF_C000
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // Core request and response
  input  logic                            core_trans_valid_i,
  output logic                            core_trans_ready_o,
  input  obi_data_req_t                   core_trans_i,
  output logic                            core_resp_valid_o,
  output data_resp_t                      core_resp_o,

  // Watchpoint settings
  input  trigger_cfg_t [NUM_TRIGGERS-1:0] trig_cfg_i,

  // Memory bus
  output logic                            bus_req_valid_o,
  input  logic                            bus_req_ready_i,
  output obi_data_req_t                   bus_req_o,
  input  logic                            bus_resp_valid_i,
  input  bus_resp_t                       bus_resp_i
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  logic          lim_trans_valid;
  logic          lim_trans_ready;
  logic          one_txn_pend_n;
  logic          trigger_match;
  logic          wpt_mpu_valid;
  logic          wpt_mpu_ready;
  obi_data_req_t wpt_mpu_trans;
  logic          mpu_wpt_resp_valid;
  data_resp_t    mpu_wpt_resp;

  // Limiter counts every transaction the core sees answered
  lsu_txn_limiter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_lsu_txn_limiter (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_resp_valid_i  (core_resp_valid_o),
    .lim_trans_valid_o  (lim_trans_valid),
    .lim_trans_ready_i  (lim_trans_ready),
    .one_txn_pend_n_o   (one_txn_pend_n)
  );

  // Trigger compare sees the request payload directly
  lsu_trigger_match #(
    .NUM_TRIGGERS (NUM_TRIGGERS)
  ) i_lsu_trigger_match (
    .trans_i         (core_trans_i),
    .trig_cfg_i      (trig_cfg_i),
    .trigger_match_o (trigger_match)
  );

  lsu_wpt i_lsu_wpt (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .trigger_match_i       (trigger_match),
    .core_trans_valid_i    (lim_trans_valid),
    .core_trans_ready_o    (lim_trans_ready),
    .core_trans_i          (core_trans_i),
    .mpu_trans_valid_o     (wpt_mpu_valid),
    .mpu_trans_ready_i     (wpt_mpu_ready),
    .mpu_trans_o           (wpt_mpu_trans),
    .mpu_resp_valid_i      (mpu_wpt_resp_valid),
    .mpu_resp_i            (mpu_wpt_resp),
    .core_resp_valid_o     (core_resp_valid_o),
    .core_resp_o           (core_resp_o),
    .core_one_txn_pend_n_i (one_txn_pend_n)
  );

  lsu_mpu #(
    .DENY_BASE (DENY_BASE),
    .DENY_MASK (DENY_MASK)
  ) i_lsu_mpu (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .core_trans_valid_i    (wpt_mpu_valid),
    .core_trans_ready_o    (wpt_mpu_ready),
    .core_trans_i          (wpt_mpu_trans),
    .core_one_txn_pend_n_i (one_txn_pend_n),
    .bus_req_valid_o       (bus_req_valid_o),
    .bus_req_ready_i       (bus_req_ready_i),
    .bus_req_o             (bus_req_o),
    .bus_resp_valid_i      (bus_resp_valid_i),
    .bus_resp_i            (bus_resp_i),
    .core_resp_valid_o     (mpu_wpt_resp_valid),
    .core_resp_o           (mpu_wpt_resp)
  );

endmodule

`default_nettype wire

//--- tb/tb_lsu_data_assert.sv
// Handshake and FSM checks, bound into lsu_wpt and lsu_mpu; state 2'b00 is the idle encoding
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_data_assert import lsu_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req_valid,
  input  logic          req_ready,
  input  obi_data_req_t req,
  input  logic          core_ready,
  input  logic [1:0]    state,
  input  logic          busy
);

  // A stalled request keeps its valid and its payload
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request dropped or changed before ready");

  // Each state machine sits in idle in the first cycle after reset
  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> state == 2'b00)
    else $error("state machine left idle right after reset");

  // While waiting or answering nothing new is taken
  a_ready_low_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !core_ready)
    else $error("core ready high while a claimed transaction is pending");

endmodule

bind lsu_wpt tb_lsu_data_assert i_wpt_assert (
  .clk(clk), .rst_n(rst_n), .req_valid(core_trans_valid_i), .req_ready(core_trans_ready_o),
  .req(core_trans_i), .core_ready(core_trans_ready_o), .state(state_q),
  .busy(state_q != WPT_IDLE)
);

bind lsu_mpu tb_lsu_data_assert i_mpu_assert (
  .clk(clk), .rst_n(rst_n), .req_valid(bus_req_valid_o), .req_ready(bus_req_ready_i),
  .req(bus_req_o), .core_ready(core_trans_ready_o), .state(state_q),
  .busy(state_q != MPU_IDLE)
);

`default_nettype wire

//--- tb/tb_lsu_data.sv
// Random testbench for lsu_data_top with default parameters; clean addresses live in 0x100..0x11C
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_data import lsu_pkg::*; ();

  localparam int          MAX_OUTSTANDING = 2;
  localparam int          N_TXN           = 300;
  localparam logic [31:0] DENY_BASE       = 32'h0000_8000;
  localparam logic [31:0] DENY_MASK       = 32'hFFFF_C000;
  localparam logic [31:0] ERR_ADDR        = 32'h0000_0118;

  logic                    clk;
  logic                    rst_n;
  logic                    core_trans_valid_i;
  logic                    core_trans_ready_o;
  obi_data_req_t           core_trans_i;
  logic                    core_resp_valid_o;
  data_resp_t              core_resp_o;
  trigger_cfg_t [1:0]      trig_cfg;
  logic                    bus_req_valid_o;
  logic                    bus_req_ready_i;
  obi_data_req_t           bus_req_o;
  logic                    bus_resp_valid_i;
  bus_resp_t               bus_resp_i;

  logic [31:0]   lcg_state;
  logic [31:0]   model_mem [0:7];
  logic [31:0]   bus_mem [0:7];
  logic [31:0]   addr_pool [0:12];
  data_resp_t    exp_q[$];
  obi_data_req_t bus_exp_q[$];
  bus_resp_t     bresp_q[$];
  int            delay_q[$];

  lsu_data_top #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .DENY_BASE       (DENY_BASE),
    .DENY_MASK       (DENY_MASK)
  ) i_lsu_data_top (
    .clk(clk), .rst_n(rst_n),
    .core_trans_valid_i(core_trans_valid_i), .core_trans_ready_o(core_trans_ready_o),
    .core_trans_i(core_trans_i), .core_resp_valid_o(core_resp_valid_o),
    .core_resp_o(core_resp_o), .trig_cfg_i(trig_cfg),
    .bus_req_valid_o(bus_req_valid_o), .bus_req_ready_i(bus_req_ready_i),
    .bus_req_o(bus_req_o), .bus_resp_valid_i(bus_resp_valid_i), .bus_resp_i(bus_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Byte lanes not enabled keep their old value
  function automatic logic [31:0] merge_bytes(logic [31:0] old_w, logic [31:0] new_w,
                                              logic [3:0] be);
    logic [31:0] mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input data_resp_t got, input data_resp_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: core response %h, expected %h", $time, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bus_req(input obi_data_req_t got, input obi_data_req_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: bus request %h, expected %h", $time, got, exp);
      stop_on_error();
    end
  endtask

  // Reference model, watchpoint then alignment then denied region then memory
  task automatic predict(input obi_data_req_t t, output data_resp_t r, output logic clean);
    logic hit;
    hit   = 1'b0;
    clean = 1'b0;
    r     = '0;
    r.mpu_status   = MPU_OK;
    r.align_status = ALIGN_OK;
    for (int i = 0; i < 2; i++) begin
      if (trig_cfg[i].addr[31:2] == t.addr[31:2] &&
          (t.we ? trig_cfg[i].match_store : trig_cfg[i].match_load)) begin
        hit = 1'b1;
      end
    end
    if (hit) begin
      r.wpt_match = 1'b1;
    end else if (t.addr[1:0] != 2'b00) begin
      r.align_status = ALIGN_ERR;
    end else if ((t.addr & DENY_MASK) == DENY_BASE) begin
      r.mpu_status = t.we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end else begin
      clean = 1'b1;
      r.bus_resp.err = (t.addr == ERR_ADDR);
      if (!r.bus_resp.err && t.we) begin
        model_mem[t.addr[4:2]] = merge_bytes(model_mem[t.addr[4:2]], t.wdata, t.be);
      end else if (!r.bus_resp.err) begin
        r.bus_resp.rdata = model_mem[t.addr[4:2]];
      end
    end
  endtask

  // Memory responder queues the reply with a random delay
  task automatic serve_bus(input obi_data_req_t t);
    bus_resp_t r;
    r.err   = (t.addr == ERR_ADDR);
    r.rdata = '0;
    if (!r.err && t.we) begin
      bus_mem[t.addr[4:2]] = merge_bytes(bus_mem[t.addr[4:2]], t.wdata, t.be);
    end else if (!r.err) begin
      r.rdata = bus_mem[t.addr[4:2]];
    end
    bresp_q.push_back(r);
    delay_q.push_back(int'(lcg_next() % 32'd4));
  endtask

  ////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////

  initial begin
    obi_data_req_t cur_req;
    data_resp_t    exp;
    logic          clean;
    logic          req_active;
    int            n_issued;
    int            n_resp;
    int            outstanding;
    int            idle_cycles;
    int            idx;

    lcg_state = 32'hba7c;
    addr_pool = '{32'h100, 32'h104, 32'h106, 32'h108, 32'h10C, 32'h110, 32'h114,
                  32'h118, 32'h11C, 32'h102, 32'h8000, 32'h8004, 32'h8001};
    for (int i = 0; i < 8; i++) begin
      // Fill word is built from the full word address
      model_mem[i] = 32'h5a5a_0000 ^ (32'h100 + 32'(i * 4)) ^ 32'(i << 20);
      bus_mem[i]   = model_mem[i];
    end
    trig_cfg[0] = '{addr: 32'h104, match_load: 1'b1, match_store: 1'b1};
    trig_cfg[1] = '{addr: 32'h8004, match_load: 1'b0, match_store: 1'b1};
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
    bus_req_ready_i    = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_resp_i         = '0;
    cur_req     = '0;
    req_active  = 1'b0;
    n_issued    = 0;
    n_resp      = 0;
    outstanding = 0;
    idle_cycles = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    while (n_resp < N_TXN) begin
      @(negedge clk);
      idle_cycles++;
      if (core_resp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Response arrived with no transaction outstanding at %0t", $time);
          stop_on_error();
        end
        check_resp(core_resp_o, exp_q.pop_front());
        n_resp++;
        outstanding--;
        idle_cycles = 0;
      end
      if (core_trans_valid_i && core_trans_ready_o) begin
        predict(cur_req, exp, clean);
        exp_q.push_back(exp);
        if (clean) begin
          bus_exp_q.push_back(cur_req);
        end
        req_active = 1'b0;
        outstanding++;
        if (outstanding > MAX_OUTSTANDING) begin
          $display("More than %0d transactions outstanding at %0t", MAX_OUTSTANDING, $time);
          stop_on_error();
        end
      end
      if (bus_req_valid_o && bus_req_ready_i) begin
        if (bus_exp_q.size() == 0) begin
          $display("Bus request for a transaction that must not reach the bus at %0t", $time);
          stop_on_error();
        end
        check_bus_req(bus_req_o, bus_exp_q.pop_front());
        serve_bus(bus_req_o);
      end
      if (delay_q.size() > 0 && delay_q[0] > 0) begin
        delay_q[0] = delay_q[0] - 1;
      end
      if (idle_cycles > 500) begin
        $display("Timeout: no response for 500 cycles at %0t", $time);
        stop_on_error();
      end

      @(posedge clk);
      if (!req_active && n_issued < N_TXN && (lcg_next() % 32'd4) != 32'd0) begin
        idx = int'(lcg_next() % 32'd13);
        cur_req.addr  = addr_pool[idx];
        cur_req.we    = lcg_next() > 32'h7fff_ffff;
        cur_req.be    = lcg_next() > 32'h3fff_ffff ? 4'hF : 4'(lcg_next() >> 28);
        cur_req.wdata = lcg_next();
        req_active = 1'b1;
        n_issued++;
        core_trans_valid_i <= 1'b1;
        core_trans_i       <= cur_req;
      end else if (!req_active) begin
        core_trans_valid_i <= 1'b0;
      end
      bus_req_ready_i <= (lcg_next() % 32'd4) != 32'd0;
      if (bresp_q.size() > 0 && delay_q[0] == 0) begin
        bus_resp_valid_i <= 1'b1;
        bus_resp_i       <= bresp_q.pop_front();
        void'(delay_q.pop_front());
      end else begin
        bus_resp_valid_i <= 1'b0;
        bus_resp_i       <= '0;
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
common/lsu_pkg.sv
verilog/lsu_trigger_match.sv
verilog/lsu_txn_limiter.sv
wpt/lsu_wpt.sv
mpu/lsu_mpu.sv
verilog/lsu_data_top.sv
tb/tb_lsu_data_assert.sv
tb/tb_lsu_data.sv

//--- run_sim.sh
#!/bin/sh
# Build the LSU data path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_lsu_data \
  -Mdir obj_dir -o sim_lsu_data
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_lsu_data 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulator returned status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
